// File: design/nacp_pkg.sv
// NACP switch shared definitions
`default_nettype none

package nacp_pkg;

	// ------------------------------------------------------------------------
	// word geometry
	// ------------------------------------------------------------------------
	localparam int DATA_W = 64;                 // one stream word
	localparam int MAC_W  = 48;                 // header bits 63:16
	localparam int TAG_W  = 16;                 // header bits 15:0, sequence tag
	localparam int ADDR_W = 20;                 // register address field
	localparam int REG_W  = 32;                 // register / command data
	localparam int CNT_W  = 16;                 // fifo occupancy and free counts

	// one stream word plus framing
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic              sop;                 // first word of packet
		logic              eop;                 // last word of packet
	} pkt_word_t;

	// second word of a control packet, also the response payload
	typedef struct packed {
		logic              write;               // bit 63, 1 = write
		logic              ok;                  // bit 62, responses only
		logic [9:0]        rsvd;                // bits 61:52, zero
		logic [ADDR_W-1:0] addr;                // bits 51:32
		logic [REG_W-1:0]  data;                // bits 31:0
	} cmd_t;

	// two-word response, header then command
	typedef struct packed {
		logic [DATA_W-1:0] hdr;                 // host mac + echoed tag
		cmd_t              cmd;
	} resp_t;

	// where the front end sends the current packet
	typedef enum logic [1:0] {
		ROUTE_DROP = 2'd0,                      // no room, discard
		ROUTE_DATA = 2'd1,                      // buffered unchanged
		ROUTE_CTRL = 2'd2                       // register command
	} route_t;

endpackage

`default_nettype wire

// File: design/pkt_if.sv
// Packet word interface
`default_nettype none

interface pkt_if;
	import nacp_pkg::*;

	logic [DATA_W-1:0] word;                    // payload word
	logic              valid;                   // single-cycle strobe per word
	logic              sop;                     // start of packet
	logic              eop;                     // end of packet

	// producer side
	modport src (
		output word,
		output valid,
		output sop,
		output eop
	);

	// consumer side
	modport snk (
		input  word,
		input  valid,
		input  sop,
		input  eop
	);

endinterface

`default_nettype wire

// File: design/pkt_fifo.sv
// Synchronous packet FIFO
`default_nettype none

module pkt_fifo #(
	parameter type T     = logic [7:0],
	parameter int  DEPTH = 4
) (
	input  logic                        i_sys_clk,
	input  logic                        i_arst_n,
	input  logic                        i_push,   // ignored when full
	input  T                            i_din,
	input  logic                        i_pop,    // ignored when empty
	output T                            o_dout,   // head entry, valid while !o_empty
	output logic                        o_empty,
	output logic                        o_full,
	output logic [nacp_pkg::CNT_W-1:0]  o_free    // entries left
);
	import nacp_pkg::*;

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	T                 mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [CNT_W-1:0] count;                    // occupancy
	logic             do_push;
	logic             do_pop;

	assign do_push = i_push && !o_full;
	assign do_pop  = i_pop && !o_empty;

	always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;   // wrap at depth
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

	always_ff @(posedge i_sys_clk) begin
		if (do_push)
			mem[wr_ptr] <= i_din;
	end

	assign o_dout  = mem[rd_ptr];                           // first-word fall-through
	assign o_empty = (count == '0);
	assign o_full  = (count == CNT_W'(DEPTH));
	assign o_free  = CNT_W'(DEPTH) - count;

endmodule

`default_nettype wire

// File: design/pkt_classify.sv
// Packet front-end classifier
`default_nettype none

module pkt_classify #(
	parameter logic [nacp_pkg::MAC_W-1:0] NACP_MAC      = 48'h888888888888,
	parameter int                         MAX_PKT_WORDS = 16
) (
	input  logic                         i_sys_clk,
	input  logic                         i_arst_n,
	input  logic [nacp_pkg::DATA_W-1:0]  i_pkt_data,
	input  logic                         i_pkt_valid,
	input  logic                         i_pkt_sop,
	input  logic                         i_pkt_eop,
	input  logic [nacp_pkg::CNT_W-1:0]   i_data_free,   // data fifo free entries
	pkt_if.src                           o_data,        // to data fifo push side
	pkt_if.src                           o_ctrl         // to command executor
);
	import nacp_pkg::*;

	route_t route_q;                            // route held from sop to eop
	route_t route_cur;                          // route of the word now at input
	logic   room;                               // enough space for a longest packet
	logic   is_ctrl;

	// the word still in o_data has not reached the fifo count yet
	assign room    = i_data_free >= CNT_W'(MAX_PKT_WORDS) + CNT_W'(o_data.valid);
	assign is_ctrl = (i_pkt_data[DATA_W-1 -: MAC_W] == NACP_MAC);   // header mac

	always_comb begin
		route_cur = route_q;
		if (i_pkt_sop)
			route_cur = is_ctrl ? ROUTE_CTRL : (room ? ROUTE_DATA : ROUTE_DROP);
	end

	always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			route_q      <= ROUTE_DROP;
			o_data.valid <= 1'b0;
			o_ctrl.valid <= 1'b0;
		end else begin
			if (i_pkt_valid)
				route_q <= i_pkt_eop ? ROUTE_DROP : route_cur;      // stray words fall away
			o_data.valid <= i_pkt_valid && (route_cur == ROUTE_DATA);
			o_ctrl.valid <= i_pkt_valid && (route_cur == ROUTE_CTRL);
		end
	end

	// payload and flags, qualified by valid
	always_ff @(posedge i_sys_clk) begin
		o_data.word <= i_pkt_data;
		o_data.sop  <= i_pkt_sop;
		o_data.eop  <= i_pkt_eop;
		o_ctrl.word <= i_pkt_data;
		o_ctrl.sop  <= i_pkt_sop;
		o_ctrl.eop  <= i_pkt_eop;
	end

endmodule

`default_nettype wire

// File: design/nacp_cmd_exec.sv
// NACP command executor
`default_nettype none

module nacp_cmd_exec #(
	parameter logic [nacp_pkg::MAC_W-1:0] HOST_MAC   = 48'h020000000001,
	parameter int                         REG_COUNT  = 16,
	parameter int                         RESP_DEPTH = 4
) (
	input  logic             i_sys_clk,
	input  logic             i_arst_n,
	pkt_if.snk               i_ctrl,            // control packets from classifier
	input  logic             i_resp_pop,
	output nacp_pkg::resp_t  o_resp,            // head response
	output logic             o_resp_empty
);
	import nacp_pkg::*;

	localparam int IDX_W = (REG_COUNT > 1) ? $clog2(REG_COUNT) : 1;

	logic [1:0]       wcnt;                     // words seen, saturates at 3
	logic [TAG_W-1:0] tag_q;                    // from header word
	cmd_t             cmd_q;                    // from second word
	logic             go_q;                     // two-word packet just ended
	logic [REG_W-1:0] regs [REG_COUNT];
	logic             ok;
	logic [IDX_W-1:0] idx;
	resp_t            resp_d;
	logic             resp_full;

	// ------------------------------------------------------------------------
	// packet framing
	// ------------------------------------------------------------------------
	always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wcnt <= '0;
			go_q <= 1'b0;
		end else begin
			go_q <= i_ctrl.valid && i_ctrl.eop && !i_ctrl.sop && (wcnt == 2'd1);
			if (i_ctrl.valid) begin
				if (i_ctrl.sop)
					wcnt <= 2'd1;
				else if (wcnt != 2'd3)
					wcnt <= wcnt + 2'd1;
			end
		end
	end

	always_ff @(posedge i_sys_clk) begin
		if (i_ctrl.valid && i_ctrl.sop)
			tag_q <= i_ctrl.word[TAG_W-1:0];          // sequence tag
		if (i_ctrl.valid && !i_ctrl.sop && (wcnt == 2'd1))
			cmd_q <= i_ctrl.word;                     // command word
	end

	// ------------------------------------------------------------------------
	// register block
	// ------------------------------------------------------------------------
	assign ok  = (cmd_q.addr < REG_COUNT);
	assign idx = cmd_q.addr[IDX_W-1:0];

	always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end else if (go_q && ok && cmd_q.write) begin
			regs[idx] <= cmd_q.data;
		end
	end

	// response built in the cycle after the command eop
	always_comb begin
		resp_d           = '0;
		resp_d.hdr       = {HOST_MAC, tag_q};
		resp_d.cmd.write = cmd_q.write;
		resp_d.cmd.ok    = ok;
		resp_d.cmd.addr  = cmd_q.addr;
		if (ok)
			resp_d.cmd.data = cmd_q.write ? cmd_q.data : regs[idx];   // echo or read
	end

	pkt_fifo #(
		.T     (resp_t),
		.DEPTH (RESP_DEPTH)
	) u_resp_fifo (
		.i_sys_clk (i_sys_clk),
		.i_arst_n  (i_arst_n),
		.i_push    (go_q && !resp_full),          // dropped when queue full
		.i_din     (resp_d),
		.i_pop     (i_resp_pop),
		.o_dout    (o_resp),
		.o_empty   (o_resp_empty),
		.o_full    (resp_full),
		.o_free    ()
	);

endmodule

`default_nettype wire

// File: design/pkt_poll_mux.sv
// Round-robin packet poller
`default_nettype none

module pkt_poll_mux (
	input  logic                         i_sys_clk,
	input  logic                         i_arst_n,
	input  nacp_pkg::pkt_word_t          i_data_word,   // data fifo head
	input  logic                         i_data_empty,
	output logic                         o_data_pop,
	input  nacp_pkg::resp_t              i_resp,        // response queue head
	input  logic                         i_resp_empty,
	output logic                         o_resp_pop,
	output logic [nacp_pkg::DATA_W-1:0]  o_pkt_data,
	output logic                         o_pkt_valid,
	output logic                         o_pkt_sop,
	output logic                         o_pkt_eop
);

	typedef enum logic [1:0] {
		S_IDLE = 2'd0,
		S_DATA = 2'd1,                          // streaming a data packet
		S_HDR  = 2'd2,                          // response header word
		S_CMD  = 2'd3                           // response command word
	} state_t;

	state_t state;
	logic   prio_resp;                          // response source wins a tie
	logic   data_rdy;
	logic   resp_rdy;

	assign data_rdy = !i_data_empty && i_data_word.sop;
	assign resp_rdy = !i_resp_empty;

	// ------------------------------------------------------------------------
	// source selection, packet granular
	// ------------------------------------------------------------------------
	always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state     <= S_IDLE;
			prio_resp <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (data_rdy && (!resp_rdy || !prio_resp)) begin
						state     <= S_DATA;
						prio_resp <= 1'b1;                    // other side next
					end else if (resp_rdy) begin
						state     <= S_HDR;
						prio_resp <= 1'b0;
					end
				end
				S_DATA: begin
					if (!i_data_empty && i_data_word.eop)
						state <= S_IDLE;
				end
				S_HDR:   state <= S_CMD;
				S_CMD:   state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// output word and pops
	// ------------------------------------------------------------------------
	always_comb begin
		o_pkt_data  = '0;
		o_pkt_valid = 1'b0;
		o_pkt_sop   = 1'b0;
		o_pkt_eop   = 1'b0;
		o_data_pop  = 1'b0;
		o_resp_pop  = 1'b0;
		case (state)
			S_IDLE: o_data_pop = !i_data_empty && !i_data_word.sop;   // flush orphan words
			S_DATA: begin
				o_pkt_data  = i_data_word.data;
				o_pkt_valid = !i_data_empty;
				o_pkt_sop   = !i_data_empty && i_data_word.sop;
				o_pkt_eop   = !i_data_empty && i_data_word.eop;
				o_data_pop  = !i_data_empty;
			end
			S_HDR: begin
				o_pkt_data  = i_resp.hdr;
				o_pkt_valid = 1'b1;
				o_pkt_sop   = 1'b1;
			end
			S_CMD: begin
				o_pkt_data  = i_resp.cmd;
				o_pkt_valid = 1'b1;
				o_pkt_eop   = 1'b1;
				o_resp_pop  = 1'b1;                          // response done
			end
			default: o_pkt_valid = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: design/nacp_switch_top.sv
// NACP switch endpoint top level
`default_nettype none

module nacp_switch_top #(
	parameter logic [nacp_pkg::MAC_W-1:0] NACP_MAC      = 48'h888888888888,
	parameter logic [nacp_pkg::MAC_W-1:0] HOST_MAC      = 48'h020000000001,
	parameter int                         REG_COUNT     = 16,
	parameter int                         DATA_DEPTH    = 64,
	parameter int                         RESP_DEPTH    = 4,
	parameter int                         MAX_PKT_WORDS = 16
) (
	input  logic                         i_sys_clk,
	input  logic                         i_arst_n,
	input  logic [nacp_pkg::DATA_W-1:0]  i_pkt_data,
	input  logic                         i_pkt_valid,
	input  logic                         i_pkt_sop,
	input  logic                         i_pkt_eop,
	output logic [nacp_pkg::DATA_W-1:0]  o_pkt_data,
	output logic                         o_pkt_valid,
	output logic                         o_pkt_sop,
	output logic                         o_pkt_eop
);
	import nacp_pkg::*;

	pkt_if data_if ();                          // classifier to data fifo
	pkt_if ctrl_if ();                          // classifier to executor

	pkt_word_t        data_din;
	pkt_word_t        data_head;
	logic [CNT_W-1:0] data_free;
	logic             data_empty;
	logic             data_pop;
	resp_t            resp_head;
	logic             resp_empty;
	logic             resp_pop;

	assign data_din = '{data: data_if.word, sop: data_if.sop, eop: data_if.eop};

	pkt_classify #(.NACP_MAC(NACP_MAC), .MAX_PKT_WORDS(MAX_PKT_WORDS)) u_pkt_classify (
		.i_sys_clk (i_sys_clk), .i_arst_n (i_arst_n),
		.i_pkt_data (i_pkt_data), .i_pkt_valid (i_pkt_valid),
		.i_pkt_sop (i_pkt_sop), .i_pkt_eop (i_pkt_eop),
		.i_data_free (data_free), .o_data (data_if.src), .o_ctrl (ctrl_if.src)
	);

	pkt_fifo #(.T(pkt_word_t), .DEPTH(DATA_DEPTH)) u_data_fifo (
		.i_sys_clk (i_sys_clk), .i_arst_n (i_arst_n),
		.i_push (data_if.valid), .i_din (data_din), .i_pop (data_pop),
		.o_dout (data_head), .o_empty (data_empty), .o_full (), .o_free (data_free)
	);

	nacp_cmd_exec #(.HOST_MAC(HOST_MAC), .REG_COUNT(REG_COUNT), .RESP_DEPTH(RESP_DEPTH))
	u_nacp_cmd_exec (
		.i_sys_clk (i_sys_clk), .i_arst_n (i_arst_n), .i_ctrl (ctrl_if.snk),
		.i_resp_pop (resp_pop), .o_resp (resp_head), .o_resp_empty (resp_empty)
	);

	pkt_poll_mux u_pkt_poll_mux (
		.i_sys_clk (i_sys_clk), .i_arst_n (i_arst_n),
		.i_data_word (data_head), .i_data_empty (data_empty), .o_data_pop (data_pop),
		.i_resp (resp_head), .i_resp_empty (resp_empty), .o_resp_pop (resp_pop),
		.o_pkt_data (o_pkt_data), .o_pkt_valid (o_pkt_valid),
		.o_pkt_sop (o_pkt_sop), .o_pkt_eop (o_pkt_eop)
	);

endmodule

`default_nettype wire

// File: verif/nacp_switch_chk.sv
// Output framing assertions
`default_nettype none

module nacp_switch_chk (
	input  logic i_sys_clk,
	input  logic i_arst_n,
	input  logic i_valid,                       // output stream of the top level
	input  logic i_sop,
	input  logic i_eop
);
	timeunit 1ns;
	timeprecision 1ps;

	logic in_pkt;                               // between sop and eop

	always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
		if (!i_arst_n)
			in_pkt <= 1'b0;
		else if (i_valid && i_eop)
			in_pkt <= 1'b0;
		else if (i_valid && i_sop)
			in_pkt <= 1'b1;
	end

	a_sop_valid: assert property (@(posedge i_sys_clk) disable iff (!i_arst_n)
		i_sop |-> i_valid) else $error("output sop without valid");
	a_eop_valid: assert property (@(posedge i_sys_clk) disable iff (!i_arst_n)
		i_eop |-> i_valid) else $error("output eop without valid");
	a_no_gap: assert property (@(posedge i_sys_clk) disable iff (!i_arst_n)
		in_pkt |-> i_valid) else $error("output valid dropped inside a packet");
	a_no_sop: assert property (@(posedge i_sys_clk) disable iff (!i_arst_n)
		in_pkt |-> !i_sop) else $error("output sop inside a packet");
	a_rst_idle: assert property (@(posedge i_sys_clk)
		!i_arst_n |-> !(i_valid || i_sop || i_eop)) else $error("output active during reset");

endmodule

bind nacp_switch_top nacp_switch_chk u_nacp_switch_chk (
	.i_sys_clk (i_sys_clk),
	.i_arst_n  (i_arst_n),
	.i_valid   (o_pkt_valid),
	.i_sop     (o_pkt_sop),
	.i_eop     (o_pkt_eop)
);

`default_nettype wire

// File: verif/tb_checker.sv
// Reference model and output checker
`default_nettype none

module tb_checker #(
	parameter logic [nacp_pkg::MAC_W-1:0] NACP_MAC  = 48'h888888888888,
	parameter logic [nacp_pkg::MAC_W-1:0] HOST_MAC  = 48'h020000000001,
	parameter int                         REG_COUNT = 16
) (
	input  logic                         i_sys_clk,
	input  logic                         i_arst_n,
	input  logic [nacp_pkg::DATA_W-1:0]  i_in_data,      // dut input side
	input  logic                         i_in_valid,
	input  logic                         i_in_sop,
	input  logic                         i_in_eop,
	input  logic [nacp_pkg::DATA_W-1:0]  i_out_data,     // dut output side
	input  logic                         i_out_valid,
	input  logic                         i_out_sop,
	input  logic                         i_out_eop,
	output int                           o_errors,
	output int                           o_pending
);
	timeunit 1ns;
	timeprecision 1ps;
	import nacp_pkg::*;

	logic [REG_W-1:0]  model_regs [REG_COUNT];
	logic [DATA_W+1:0] exp_data [$];            // {sop, eop, word}
	logic [DATA_W+1:0] exp_resp [$];
	logic [DATA_W-1:0] ctrl_words [$];          // control packet being received
	logic              in_ctrl   = 1'b0;
	logic              out_resp  = 1'b0;        // current output packet is a response
	int                errors    = 0;
	int                pushed    = 0;
	int                popped    = 0;

	assign o_errors  = errors;
	assign o_pending = pushed - popped;

	// expected response {header, command} for one two-word command
	function automatic logic [2*DATA_W-1:0] nacp_ref(input logic [DATA_W-1:0] hdr,
			input logic [DATA_W-1:0] cmd);
		logic              ok;
		logic [REG_W-1:0]  rdata;
		ok    = (int'(cmd[51:32]) < REG_COUNT);
		rdata = '0;
		if (ok)
			rdata = cmd[63] ? cmd[31:0] : model_regs[int'(cmd[51:32])];   // echo or read
		return {HOST_MAC, hdr[15:0], cmd[63], ok, 10'h0, cmd[51:32], rdata};
	endfunction

	task automatic compare_field(input string name, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	// ------------------------------------------------------------------------
	// input side, builds the expected queues
	// ------------------------------------------------------------------------
	always @(posedge i_sys_clk or negedge i_arst_n) begin : watch_input
		logic                ctrl_now;
		logic [2*DATA_W-1:0] resp;
		if (!i_arst_n) begin
			foreach (model_regs[i])
				model_regs[i] = '0;                  // registers clear on reset
			in_ctrl = 1'b0;
		end else if (i_in_valid) begin
			ctrl_now = i_in_sop ? (i_in_data[DATA_W-1 -: MAC_W] == NACP_MAC) : in_ctrl;
			if (i_in_sop) begin
				in_ctrl = ctrl_now;
				ctrl_words.delete();
			end
			if (ctrl_now) begin
				ctrl_words.push_back(i_in_data);
				if (i_in_eop && ctrl_words.size() == 2) begin   // only two-word commands
					resp = nacp_ref(ctrl_words[0], ctrl_words[1]);
					exp_resp.push_back({2'b10, resp[2*DATA_W-1:DATA_W]});
					exp_resp.push_back({2'b01, resp[DATA_W-1:0]});
					pushed += 2;
					if (resp[63] && resp[62])
						model_regs[int'(resp[51:32])] = resp[31:0];
				end
			end else begin
				exp_data.push_back({i_in_sop, i_in_eop, i_in_data});
				pushed++;
			end
		end
	end

	// ------------------------------------------------------------------------
	// output side, mid-cycle sample
	// ------------------------------------------------------------------------
	always @(negedge i_sys_clk) begin : watch_output
		logic [DATA_W+1:0] exp;
		logic              empty;
		if (i_arst_n && i_out_valid) begin
			if (i_out_sop)
				out_resp = (i_out_data[DATA_W-1 -: MAC_W] == HOST_MAC);   // stream by mac
			empty = out_resp ? (exp_resp.size() == 0) : (exp_data.size() == 0);
			if (empty) begin
				errors++;
				$display("unexpected output word 0x%0h at %0t, no %s packet was expected",
					i_out_data, $time, out_resp ? "response" : "data");
			end else begin
				if (out_resp)
					exp = exp_resp.pop_front();
				else
					exp = exp_data.pop_front();
				popped++;
				compare_field("o_pkt_data", i_out_data, exp[DATA_W-1:0]);
				compare_field("o_pkt_sop", DATA_W'(i_out_sop), DATA_W'(exp[DATA_W+1]));
				compare_field("o_pkt_eop", DATA_W'(i_out_eop), DATA_W'(exp[DATA_W]));
			end
		end
	end

endmodule

`default_nettype wire

// File: verif/tb_top.sv
// NACP switch testbench top
`default_nettype none

module tb_top;
	timeunit 1ns;
	timeprecision 1ps;
	import nacp_pkg::*;

	localparam logic [MAC_W-1:0] NACP_MAC      = 48'h888888888888;
	localparam logic [MAC_W-1:0] HOST_MAC      = 48'h020000000001;
	localparam int               REG_COUNT     = 16;
	localparam int               MAX_PKT_WORDS = 16;

	logic              sys_clk;
	logic              arst_n;
	logic [DATA_W-1:0] pkt_data;
	logic              pkt_valid, pkt_sop, pkt_eop;
	logic [DATA_W-1:0] out_data;
	logic              out_valid, out_sop, out_eop;
	int                errors;                  // mismatches seen by the checker
	int                pending;                 // expected words not yet seen
	int                seed      = 32'h3b04f5aa;
	int                wd_cycles;               // watchdog budget
	logic              wd_armed  = 1'b0;
	logic [TAG_W-1:0]  tag       = '0;          // next sequence tag
	logic [DATA_W+2:0] stim_q [$];              // {valid, sop, eop, data} per cycle

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;         // 100 ns period
	end

	nacp_switch_top #(
		.NACP_MAC      (NACP_MAC),
		.HOST_MAC      (HOST_MAC),
		.REG_COUNT     (REG_COUNT),
		.MAX_PKT_WORDS (MAX_PKT_WORDS)
	) u_nacp_switch_top (
		.i_sys_clk (sys_clk), .i_arst_n (arst_n),
		.i_pkt_data (pkt_data), .i_pkt_valid (pkt_valid),
		.i_pkt_sop (pkt_sop), .i_pkt_eop (pkt_eop),
		.o_pkt_data (out_data), .o_pkt_valid (out_valid),
		.o_pkt_sop (out_sop), .o_pkt_eop (out_eop)
	);

	tb_checker #(.NACP_MAC(NACP_MAC), .HOST_MAC(HOST_MAC), .REG_COUNT(REG_COUNT)) u_tb_checker (
		.i_sys_clk (sys_clk), .i_arst_n (arst_n),
		.i_in_data (pkt_data), .i_in_valid (pkt_valid), .i_in_sop (pkt_sop), .i_in_eop (pkt_eop),
		.i_out_data (out_data), .i_out_valid (out_valid),
		.i_out_sop (out_sop), .i_out_eop (out_eop),
		.o_errors (errors), .o_pending (pending)
	);

	// ------------------------------------------------------------------------
	// stimulus building
	// ------------------------------------------------------------------------
	function automatic logic [31:0] rnd();
		return $random(seed);
	endfunction

	function automatic logic [ADDR_W-1:0] rand_addr();
		return ADDR_W'(rnd() % (REG_COUNT + 4));       // a few out of range
	endfunction

	task automatic add_word(input logic sop, input logic eop, input logic [DATA_W-1:0] data);
		stim_q.push_back({1'b1, sop, eop, data});
	endtask

	task automatic add_gap(input int n);
		repeat (n) stim_q.push_back('0);
	endtask

	task automatic add_data_pkt(input int len);
		logic [63:0]      r;
		logic [MAC_W-1:0] mac;
		r   = {rnd(), rnd()};
		mac = r[MAC_W-1:0];
		if (mac == NACP_MAC || mac == HOST_MAC)
			mac = 48'h0a0b0c0d0e0f;                  // keep it a data packet
		add_word(1'b1, len == 1, {mac, r[63:48]});
		for (int i = 1; i < len; i++)
			add_word(1'b0, i == len - 1, {rnd(), rnd()});
		add_gap(3 + int'(rnd() % 2));               // keeps the fifos draining
	endtask

	task automatic add_ctrl(input int nwords, input logic wr, input logic [ADDR_W-1:0] addr,
			input logic [REG_W-1:0] data);
		add_word(1'b1, nwords == 1, {NACP_MAC, tag});
		for (int i = 1; i < nwords; i++)
			add_word(1'b0, i == nwords - 1, {wr, 1'b0, 10'h0, addr, data});
		tag = tag + 16'd1;
		add_gap(3 + int'(rnd() % 2));
	endtask

	task automatic build_stimulus();
		logic [31:0] r;
		add_gap(8);                                  // idle output after reset
		for (int a = 0; a < REG_COUNT; a++)
			add_ctrl(2, 1'b0, ADDR_W'(a), '0);       // every register reads zero
		add_data_pkt(1);
		add_data_pkt(MAX_PKT_WORDS);
		for (int p = 0; p < 24; p++)
			add_data_pkt(1 + int'(rnd() % MAX_PKT_WORDS));
		for (int a = 0; a < REG_COUNT; a++) begin
			add_ctrl(2, 1'b1, ADDR_W'(a), rnd());   // write then read back
			add_ctrl(2, 1'b0, ADDR_W'(a), '0);
		end
		add_ctrl(2, 1'b1, ADDR_W'(REG_COUNT), 32'hdeadbeef);   // out of range
		add_ctrl(2, 1'b0, ADDR_W'(REG_COUNT), '0);
		add_ctrl(2, 1'b1, 20'hfffff, 32'h12345678);
		for (int a = 0; a < REG_COUNT; a++)
			add_ctrl(2, 1'b0, ADDR_W'(a), '0);       // nothing moved
		for (int p = 0; p < 8; p++) begin
			add_data_pkt(1 + int'(rnd() % MAX_PKT_WORDS));
			add_ctrl(1, 1'b1, rand_addr(), rnd());  // too short, ignored
			add_ctrl(2, 1'b1, rand_addr(), rnd());
			add_ctrl(3, 1'b1, rand_addr(), rnd());  // too long, ignored
			add_data_pkt(1 + int'(rnd() % MAX_PKT_WORDS));
			add_ctrl(2, 1'b0, rand_addr(), '0);
		end
		for (int p = 0; p < 300; p++) begin
			r = rnd();
			case (r[2:0])
				3'd0, 3'd1, 3'd2: add_data_pkt(1 + int'(rnd() % MAX_PKT_WORDS));
				3'd7:             add_ctrl(r[3] ? 3 : 1, r[4], rand_addr(), rnd());
				default:          add_ctrl(2, r[4], rand_addr(), rnd());
			endcase
		end
	endtask

	// ------------------------------------------------------------------------
	// run and report
	// ------------------------------------------------------------------------
	initial begin : stimulus
		arst_n    = 1'b0;
		pkt_data  = '0;
		pkt_valid = 1'b0;
		pkt_sop   = 1'b0;
		pkt_eop   = 1'b0;
		build_stimulus();
		wd_cycles = stim_q.size() * 4 + 200;
		repeat (10) @(posedge sys_clk);
		@(negedge sys_clk);
		arst_n   = 1'b1;
		wd_armed = 1'b1;
		foreach (stim_q[i]) begin
			@(negedge sys_clk);
			{pkt_valid, pkt_sop, pkt_eop, pkt_data} = stim_q[i];
		end
		@(posedge sys_clk);
		wait (pending == 0);
		repeat (20) @(negedge sys_clk);             // stray words would show here
		$display("checker: %0d mismatches, %0d expected words missing", errors, pending);
		if (errors == 0 && pending == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin : watchdog
		wait (wd_armed);
		repeat (wd_cycles) @(posedge sys_clk);
		$display("timeout: output did not drain within %0d cycles, %0d words missing",
			wd_cycles, pending);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
design/nacp_pkg.sv
design/pkt_if.sv
design/pkt_fifo.sv
design/pkt_classify.sv
design/nacp_cmd_exec.sv
design/pkt_poll_mux.sv
design/nacp_switch_top.sv
verif/nacp_switch_chk.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: Makefile
# Verilator build and run, override any variable on the command line
VERILATOR ?= verilator
TOP       ?= tb_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' sim.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) sim.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sim.f

# pass only when the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf $(OBJ_DIR)
